// ==== hdl/memPkg.sv ====
package memPkg;

	// Task memory geometry
	localparam int TaskMemDepth = 64;
	localparam int TaskAddrWidth = 6;
	localparam int TaskWordWidth = 80;

	// Instruction words use the low part of a task word
	localparam int InsnWidth = 32;

	// Header word layout
	localparam int FrameLenLsb = 0;     // Instruction count
	localparam int FrameLenWidth = 6;
	localparam int FenceLsb = 6;        // 2-bit fence code
	localparam int ActiveMaskLsb = 8;   // One bit per core
	localparam int R0MaskLsb = 12;      // One bit per core
	localparam int R0ValuesLsb = 16;    // Core 0 value in lowest slice

endpackage

// ==== hdl/schedPkg.sv ====
package schedPkg;

	// Core array
	localparam int CoreCount = 4;
	localparam int RegWidth = 16;

	// Fence codes from the header word
	localparam int FenceWidth = 2;
	localparam logic [FenceWidth-1:0] FenceNone = 2'd0;
	localparam logic [FenceWidth-1:0] FenceAcquire = 2'd1;   // Wait for selected cores first
	localparam logic [FenceWidth-1:0] FenceRelease = 2'd2;   // Wait for all cores afterwards
	localparam logic [FenceWidth-1:0] FenceHalt = 2'd3;      // End of program

	// Scheduler FSM states
	typedef enum logic [2:0] {
		idle = 3'd0,
		fetchHeader = 3'd1,
		decode = 3'd2,
		waitAcquire = 3'd3,
		issue = 3'd4,
		stream = 3'd5,
		waitRelease = 3'd6
	} schedState;

endpackage

// ==== hdl/taskMemory.sv ====
`timescale 1ns/1ps

module taskMemory (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               loadStrobe,
	input  logic [memPkg::TaskAddrWidth-1:0]   loadAddr,
	input  logic [memPkg::TaskWordWidth-1:0]   loadData,
	input  logic                               busy,
	input  logic                               readStrobe,
	input  logic [memPkg::TaskAddrWidth-1:0]   readAddr,
	output logic [memPkg::TaskWordWidth-1:0]   readData
);

	import memPkg::*;

	logic [TaskWordWidth-1:0] taskRam [TaskMemDepth];
	logic writeEnable;

	// Program may only change while the scheduler is idle
	assign writeEnable = loadStrobe && !busy && !reset;

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			taskRam[loadAddr] <= loadData;
		end
	end

	// One cycle read latency
	always_ff @(posedge clk) begin
		if (readStrobe) begin
			readData <= taskRam[readAddr];
		end
	end

endmodule

// ==== hdl/fetchCounter.sv ====
`timescale 1ns/1ps

module fetchCounter (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               clearPointer,
	input  logic                               loadHeader,
	input  logic                               advance,
	input  logic [memPkg::FrameLenWidth-1:0]   frameLen,
	output logic [memPkg::TaskAddrWidth-1:0]   taskPointer,
	output logic                               last
);

	import memPkg::*;

	logic [FrameLenWidth-1:0] remaining;   // Instruction words left in frame
	logic [TaskAddrWidth-1:0] nextPointer;

	// Pointer wraps at the end of the task memory
	assign nextPointer = (taskPointer == TaskAddrWidth'(TaskMemDepth - 1)) ?
		'0 : taskPointer + 1'b1;

	always_ff @(posedge clk) begin
		if (reset || clearPointer) begin
			taskPointer <= '0;
			remaining <= '0;
		end else begin
			if (advance) begin
				taskPointer <= nextPointer;
			end
			if (loadHeader) begin
				remaining <= frameLen;
			end else if (advance && remaining != '0) begin
				remaining <= remaining - 1'b1;   // Header reads leave it at zero
			end
		end
	end

	assign last = (remaining == '0);

endmodule

// ==== hdl/coreDispatch.sv ====
`timescale 1ns/1ps

module coreDispatch (
	input  logic                                            clk,
	input  logic                                            reset,
	input  logic [memPkg::TaskWordWidth-1:0]                readData,
	input  logic [schedPkg::CoreCount-1:0]                  ready,
	input  logic                                            headerStrobe,
	input  logic                                            issueStrobe,
	input  logic                                            insnStrobe,
	output logic [schedPkg::FenceWidth-1:0]                 fence,
	output logic [memPkg::FrameLenWidth-1:0]                frameLen,
	output logic                                            activeReady,
	output logic                                            allReady,
	output logic [schedPkg::CoreCount-1:0]                  start,
	output logic [schedPkg::CoreCount-1:0]                  initR0Vect,
	output logic [schedPkg::CoreCount*schedPkg::RegWidth-1:0] initR0,
	output logic                                            insnValid,
	output logic [memPkg::InsnWidth-1:0]                    insnData
);

	import memPkg::*;
	import schedPkg::*;

	logic [FenceWidth-1:0] fenceReg;
	logic [FrameLenWidth-1:0] frameLenReg;
	logic [CoreCount-1:0] activeMask;
	logic [CoreCount-1:0] r0Mask;
	logic [CoreCount*RegWidth-1:0] r0Values;

	logic [CoreCount-1:0] curActive;
	logic [CoreCount-1:0] curR0Mask;
	logic [CoreCount*RegWidth-1:0] curR0Values;

	// Header fields are visible in the decode cycle itself
	assign fence = headerStrobe ? readData[FenceLsb +: FenceWidth] : fenceReg;
	assign frameLen = headerStrobe ? readData[FrameLenLsb +: FrameLenWidth] : frameLenReg;
	assign curActive = headerStrobe ? readData[ActiveMaskLsb +: CoreCount] : activeMask;
	assign curR0Mask = headerStrobe ? readData[R0MaskLsb +: CoreCount] : r0Mask;
	assign curR0Values = headerStrobe ? readData[R0ValuesLsb +: CoreCount*RegWidth] : r0Values;

	always_ff @(posedge clk) begin
		if (reset) begin
			fenceReg <= FenceNone;
			frameLenReg <= '0;
			activeMask <= '0;
		end else if (headerStrobe) begin
			fenceReg <= readData[FenceLsb +: FenceWidth];
			frameLenReg <= readData[FrameLenLsb +: FrameLenWidth];
			activeMask <= readData[ActiveMaskLsb +: CoreCount];
		end
	end

	always_ff @(posedge clk) begin
		if (headerStrobe) begin
			r0Mask <= readData[R0MaskLsb +: CoreCount];
			r0Values <= readData[R0ValuesLsb +: CoreCount*RegWidth];
		end
	end

	// Cores outside the active mask do not hold up an acquire
	assign activeReady = &(ready | ~activeMask);
	assign allReady = &ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			start <= '0;
			insnValid <= 1'b0;
		end else begin
			start <= issueStrobe ? curActive : '0;   // Single-cycle pulse
			insnValid <= insnStrobe;
		end
	end

	// Presets only meaningful while start is nonzero
	always_ff @(posedge clk) begin
		if (issueStrobe) begin
			initR0Vect <= curR0Mask;
			initR0 <= curR0Values;
		end
		if (insnStrobe) begin
			insnData <= readData[InsnWidth-1:0];
		end
	end

endmodule

// ==== hdl/dispatchFsm.sv ====
`timescale 1ns/1ps

module dispatchFsm (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              run,
	input  logic [schedPkg::FenceWidth-1:0]   fence,
	input  logic                              last,
	input  logic                              activeReady,
	input  logic                              allReady,
	output logic                              readStrobe,
	output logic                              headerStrobe,
	output logic                              issueStrobe,
	output logic                              insnStrobe,
	output logic                              loadHeader,
	output logic                              advance,
	output logic                              clearPointer,
	output logic                              busy,
	output logic                              done
);

	import schedPkg::*;

	schedState state;
	schedState nextState;
	schedState afterFrame;

	logic headerRead;    // Header word read this cycle
	logic instrRead;     // Instruction word read this cycle
	logic insnPending;   // Instruction data returns next cycle
	logic haltSeen;

	// Where to go once the frame has been streamed
	assign afterFrame = (fence == FenceRelease) ? waitRelease : fetchHeader;
	assign haltSeen = (state == decode) && (fence == FenceHalt);

	always_comb begin
		nextState = state;
		headerRead = 1'b0;
		instrRead = 1'b0;
		headerStrobe = 1'b0;
		issueStrobe = 1'b0;
		loadHeader = 1'b0;
		clearPointer = 1'b0;
		case (state)
			idle: begin
				if (run) begin
					clearPointer = 1'b1;
					nextState = fetchHeader;
				end
			end
			fetchHeader: begin
				headerRead = 1'b1;
				nextState = decode;
			end
			decode: begin
				headerStrobe = 1'b1;
				loadHeader = 1'b1;
				case (fence)
					FenceHalt: nextState = idle;
					FenceAcquire: nextState = waitAcquire;
					default: begin
						issueStrobe = 1'b1;   // Start shows next cycle
						nextState = issue;
					end
				endcase
			end
			waitAcquire: begin
				if (activeReady) begin
					issueStrobe = 1'b1;
					nextState = issue;
				end
			end
			issue: begin
				// Start is on the core outputs during this cycle
				if (last) begin
					nextState = afterFrame;   // Empty frame
				end else begin
					instrRead = 1'b1;
					nextState = stream;
				end
			end
			stream: begin
				if (last) begin
					nextState = afterFrame;
				end else begin
					instrRead = 1'b1;
				end
			end
			waitRelease: begin
				if (allReady) begin
					nextState = fetchHeader;
				end
			end
			default: nextState = idle;
		endcase
	end

	assign readStrobe = headerRead || instrRead;
	assign advance = headerRead || instrRead;
	assign insnStrobe = insnPending;
	assign busy = (state != idle);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			insnPending <= 1'b0;
			done <= 1'b0;
		end else begin
			state <= nextState;
			insnPending <= instrRead;
			done <= haltSeen;   // Same cycle as busy falling
		end
	end

endmodule

// ==== hdl/taskScheduler.sv ====
`timescale 1ns/1ps

module taskScheduler (
	input  logic                                            clk,
	input  logic                                            reset,
	input  logic                                            loadStrobe,
	input  logic [memPkg::TaskAddrWidth-1:0]                loadAddr,
	input  logic [memPkg::TaskWordWidth-1:0]                loadData,
	input  logic                                            run,
	input  logic [schedPkg::CoreCount-1:0]                  ready,
	output logic [schedPkg::CoreCount-1:0]                  start,
	output logic [schedPkg::CoreCount-1:0]                  initR0Vect,
	output logic [schedPkg::CoreCount*schedPkg::RegWidth-1:0] initR0,
	output logic                                            insnValid,
	output logic [memPkg::InsnWidth-1:0]                    insnData,
	output logic                                            done,
	output logic                                            busy
);

	import memPkg::*;
	import schedPkg::*;

	logic readStrobe;
	logic headerStrobe;
	logic issueStrobe;
	logic insnStrobe;
	logic loadHeader;
	logic advance;
	logic clearPointer;
	logic last;
	logic activeReady;
	logic allReady;
	logic [TaskAddrWidth-1:0] taskPointer;
	logic [TaskWordWidth-1:0] readData;
	logic [FenceWidth-1:0] fence;
	logic [FrameLenWidth-1:0] frameLen;

	taskMemory memory (
		.clk(clk), .reset(reset), .loadStrobe(loadStrobe), .loadAddr(loadAddr),
		.loadData(loadData), .busy(busy), .readStrobe(readStrobe),
		.readAddr(taskPointer), .readData(readData)
	);

	fetchCounter counter (
		.clk(clk), .reset(reset), .clearPointer(clearPointer), .loadHeader(loadHeader),
		.advance(advance), .frameLen(frameLen), .taskPointer(taskPointer), .last(last)
	);

	coreDispatch dispatch (
		.clk(clk), .reset(reset), .readData(readData), .ready(ready),
		.headerStrobe(headerStrobe), .issueStrobe(issueStrobe), .insnStrobe(insnStrobe),
		.fence(fence), .frameLen(frameLen), .activeReady(activeReady), .allReady(allReady),
		.start(start), .initR0Vect(initR0Vect), .initR0(initR0),
		.insnValid(insnValid), .insnData(insnData)
	);

	dispatchFsm fsm (
		.clk(clk), .reset(reset), .run(run), .fence(fence), .last(last),
		.activeReady(activeReady), .allReady(allReady), .readStrobe(readStrobe),
		.headerStrobe(headerStrobe), .issueStrobe(issueStrobe), .insnStrobe(insnStrobe),
		.loadHeader(loadHeader), .advance(advance), .clearPointer(clearPointer),
		.busy(busy), .done(done)
	);

endmodule

// ==== verification/schedulerTb.sv ====
`timescale 1ns/1ps

module schedulerTb;

	import memPkg::*;
	import schedPkg::*;

	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 16;
	localparam int ProgramCount = 4;
	localparam int MaxFrames = 8;
	localparam int CyclesPerFrame = 200;

	logic clk;
	logic reset;
	logic loadStrobe;
	logic [TaskAddrWidth-1:0] loadAddr;
	logic [TaskWordWidth-1:0] loadData;
	logic run;
	logic [CoreCount-1:0] ready;
	logic [CoreCount-1:0] start;
	logic [CoreCount-1:0] initR0Vect;
	logic [CoreCount*RegWidth-1:0] initR0;
	logic insnValid;
	logic [InsnWidth-1:0] insnData;
	logic done;
	logic busy;

	integer seed;
	logic [TaskWordWidth-1:0] progMem [TaskMemDepth];   // Copy of the loaded program
	int haltAddr;
	int programIdx;

	int expFrames;
	logic [CoreCount-1:0] expStart [MaxFrames];
	logic [CoreCount-1:0] expR0Mask [MaxFrames];
	logic [CoreCount*RegWidth-1:0] expR0Val [MaxFrames];
	logic [FenceWidth-1:0] expFence [MaxFrames];
	int expLen [MaxFrames];
	logic [InsnWidth-1:0] expInsn [MaxFrames][TaskMemDepth];

	int cycleCount;
	int frameIdx;      // Next frame expected to start
	int curFrame;
	int startCycle;
	int insnLeft;      // Words still owed by the current frame
	int dueCycle;
	int doneCount;
	int errorCount;
	bit releasePending;
	logic [CoreCount-1:0] prevReady;
	logic [CoreCount-1:0] startSeen;
	int holdCycles [CoreCount];
	int watchCycles;
	int watchLimit;
	bit watchArmed;

	taskScheduler DUT (
		.clk(clk), .reset(reset), .loadStrobe(loadStrobe), .loadAddr(loadAddr),
		.loadData(loadData), .run(run), .ready(ready), .start(start),
		.initR0Vect(initR0Vect), .initR0(initR0), .insnValid(insnValid),
		.insnData(insnData), .done(done), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	task automatic reportFailure(input string what);
		errorCount++;
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	function automatic logic [TaskWordWidth-1:0] makeHeader(input int len, input int fence);
		logic [TaskWordWidth-1:0] hdr;
		logic [CoreCount*RegWidth-1:0] values;
		values = {$random(seed), $random(seed)};
		hdr = '0;
		hdr[FrameLenLsb +: FrameLenWidth] = FrameLenWidth'(len);
		hdr[FenceLsb +: FenceWidth] = FenceWidth'(fence);
		hdr[ActiveMaskLsb +: CoreCount] = CoreCount'(1 + $unsigned($random(seed)) % 15);
		hdr[R0MaskLsb +: CoreCount] = CoreCount'($random(seed));
		hdr[R0ValuesLsb +: CoreCount*RegWidth] = values;
		return hdr;
	endfunction

	task automatic makeProgram();
		int frames;
		int len;
		int addr;
		logic [TaskAddrWidth-1:0] fillAddr;
		logic [95:0] wide;
		for (int a = 0; a < TaskMemDepth; a++) begin
			fillAddr = TaskAddrWidth'(a);
			progMem[a] = {10{2'b10, fillAddr}};   // Unused words carry their address
		end
		frames = 3 + $unsigned($random(seed)) % 4;
		addr = 0;
		for (int f = 0; f < frames; f++) begin
			len = $unsigned($random(seed)) % 7;
			progMem[addr] = makeHeader(len, $unsigned($random(seed)) % 3);   // None, acquire, release
			addr++;
			for (int k = 0; k < len; k++) begin
				wide = {$random(seed), $random(seed), $random(seed)};
				progMem[addr] = wide[TaskWordWidth-1:0];
				addr++;
			end
		end
		haltAddr = addr;
		progMem[addr] = makeHeader($unsigned($random(seed)) % 7, FenceHalt);
	endtask

	// Expected start events and instruction words, in program order
	function automatic int buildExpected();
		int addr;
		int frames;
		bit halted;
		logic [TaskWordWidth-1:0] hdr;
		addr = 0;
		frames = 0;
		halted = 1'b0;
		while (!halted && frames < MaxFrames) begin
			hdr = progMem[addr];
			addr = (addr + 1) % TaskMemDepth;
			if (hdr[FenceLsb +: FenceWidth] == FenceHalt) begin
				halted = 1'b1;
			end else begin
				expStart[frames] = hdr[ActiveMaskLsb +: CoreCount];
				expR0Mask[frames] = hdr[R0MaskLsb +: CoreCount];
				expR0Val[frames] = hdr[R0ValuesLsb +: CoreCount*RegWidth];
				expFence[frames] = hdr[FenceLsb +: FenceWidth];
				expLen[frames] = hdr[FrameLenLsb +: FrameLenWidth];
				for (int k = 0; k < expLen[frames]; k++) begin
					expInsn[frames][k] = progMem[addr][InsnWidth-1:0];
					addr = (addr + 1) % TaskMemDepth;
				end
				frames++;
			end
		end
		return frames;
	endfunction

	task automatic loadProgram();
		for (int a = 0; a < TaskMemDepth; a++) begin
			@(posedge clk);
			loadStrobe <= 1'b1;
			loadAddr <= TaskAddrWidth'(a);
			loadData <= progMem[a];
		end
		@(posedge clk);
		loadStrobe <= 1'b0;
	endtask

	task automatic checkStart();
		assert (frameIdx < expFrames) else reportFailure("start pulsed with no frame left");
		assert (!releasePending)
			else reportFailure("start pulsed before all cores were ready after a release frame");
		assert (insnLeft == 0)
			else reportFailure("start pulsed before the previous frame finished streaming");
		assert (start == expStart[frameIdx])
			else reportFailure($sformatf("CHECK FAILED start: got %h, expected %h",
				start, expStart[frameIdx]));
		assert (initR0Vect == expR0Mask[frameIdx])
			else reportFailure($sformatf("CHECK FAILED initR0Vect: got %h, expected %h",
				initR0Vect, expR0Mask[frameIdx]));
		assert (initR0 == expR0Val[frameIdx])
			else reportFailure($sformatf("CHECK FAILED initR0: got %h, expected %h",
				initR0, expR0Val[frameIdx]));
		if (expFence[frameIdx] == FenceAcquire) begin
			assert ((prevReady & start) == start)
				else reportFailure("Acquire frame started while a selected core was not ready");
		end
		curFrame = frameIdx;
		startCycle = cycleCount;
		insnLeft = expLen[frameIdx];
		releasePending = (expFence[frameIdx] == FenceRelease);
		frameIdx++;
	endtask

	// Core model works from a mid-cycle copy of start
	always @(negedge clk) begin
		startSeen = start;
	end

	always @(posedge clk) begin
		for (int i = 0; i < CoreCount; i++) begin
			if (reset) begin
				holdCycles[i] <= 0;
				ready[i] <= 1'b1;
			end else if (startSeen[i]) begin
				holdCycles[i] <= 1 + $unsigned($random(seed)) % 8;   // Busy for 1 to 8 cycles
				ready[i] <= 1'b0;
			end else if (holdCycles[i] > 1) begin
				holdCycles[i] <= holdCycles[i] - 1;
			end else begin
				holdCycles[i] <= 0;
				ready[i] <= 1'b1;
			end
		end
	end

	// Compare process samples in the middle of each cycle
	always @(negedge clk) begin
		if (!reset) begin
			cycleCount++;
			if (start != '0) begin
				checkStart();
			end else if (releasePending && ready == '1) begin
				releasePending = 1'b0;
			end
			dueCycle = startCycle + 2 + expLen[curFrame] - insnLeft;   // Words arrive back to back
			if (insnLeft > 0 && cycleCount == dueCycle) begin
				assert (insnValid) else reportFailure("An instruction strobe was missing");
			end
			if (insnValid) begin
				assert (insnLeft > 0 && cycleCount == dueCycle)
					else reportFailure("insnValid pulsed outside the frame's instruction window");
				assert (insnData == expInsn[curFrame][expLen[curFrame] - insnLeft])
					else reportFailure($sformatf("CHECK FAILED insnData: got %h, expected %h",
						insnData, expInsn[curFrame][expLen[curFrame] - insnLeft]));
				insnLeft--;
			end
			if (done) begin
				assert (frameIdx == expFrames && insnLeft == 0)
					else reportFailure("done pulsed before the program was complete");
				assert (!releasePending)
					else reportFailure("done pulsed before all cores were ready after a release");
				assert (!busy) else reportFailure("busy was still high in the done cycle");
				doneCount++;
			end
			prevReady = ready;
		end
	end

	always @(negedge clk) begin
		if (watchArmed) begin
			watchCycles++;
			if (watchCycles > watchLimit) begin
				reportFailure($sformatf("Watchdog expired, the scheduler never finished program %0d",
					programIdx));
			end
		end
	end

	task automatic runProgram(input int index);
		int doneBefore;
		programIdx = index;
		makeProgram();
		expFrames = buildExpected();
		frameIdx = 0;
		insnLeft = 0;
		releasePending = 1'b0;
		watchLimit = CyclesPerFrame * (expFrames + 1) + TaskMemDepth + 8;
		watchCycles = 0;
		watchArmed = 1'b1;
		loadProgram();
		doneBefore = doneCount;
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
		@(negedge clk);
		assert (busy) else reportFailure("busy did not rise after the run strobe");
		// Overwrite the halt header and strobe run again while busy
		@(posedge clk);
		run <= 1'b1;
		loadStrobe <= 1'b1;
		loadAddr <= TaskAddrWidth'(haltAddr);
		loadData <= makeHeader(0, FenceNone);
		@(posedge clk);
		run <= 1'b0;
		loadStrobe <= 1'b0;
		while (doneCount == doneBefore) begin
			@(posedge clk);
		end
		repeat (4) @(negedge clk);
		assert (!busy) else reportFailure("busy went high again after done");
		@(posedge clk);
		assert (doneCount == doneBefore + 1) else reportFailure("More than one done pulse");
		watchArmed = 1'b0;
	endtask

	initial begin
		seed = 48935;
		reset = 1'b1;
		loadStrobe = 1'b0;
		loadAddr = '0;
		loadData = '0;
		run = 1'b0;
		ready = '1;
		startSeen = '0;
		prevReady = '1;
		cycleCount = 0;
		frameIdx = 0;
		curFrame = 0;
		startCycle = 0;
		insnLeft = 0;
		expFrames = 0;
		expLen[0] = 0;
		doneCount = 0;
		errorCount = 0;
		releasePending = 1'b0;
		watchArmed = 1'b0;
		watchCycles = 0;
		watchLimit = 0;
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (start == '0 && insnValid == 1'b0 && done == 1'b0 && busy == 1'b0)
			else reportFailure("Outputs were not idle after reset");
		for (int p = 0; p < ProgramCount; p++) begin
			runProgram(p);
		end
		if (errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/memPkg.sv
hdl/schedPkg.sv
hdl/taskMemory.sv
hdl/fetchCounter.sv
hdl/coreDispatch.sv
hdl/dispatchFsm.sv
hdl/taskScheduler.sv
verification/schedulerTb.sv
